//--- source/lc3Pkg.sv
package lc3Pkg;

	typedef logic [15:0] word_t;	// One data or address word.
	typedef logic [2:0] regAddr_t;	// Index into the general register file.
	typedef logic [2:0] nzp_t;	// Condition codes, N in bit 2 and P in bit 0.

	typedef enum logic [1:0]
	{
		aluAdd = 2'b00,
		aluAnd = 2'b01,
		aluNot = 2'b10,
		aluPass = 2'b11
	} aluOp_t;

	typedef enum logic [1:0]
	{
		pcInc = 2'b00,
		pcAddr = 2'b01,
		pcBus = 2'b10
	} pcSel_t;

	// Offset width taken from the instruction register.
	typedef enum logic [1:0]
	{
		off0 = 2'b00,
		off6 = 2'b01,
		off9 = 2'b10,
		off11 = 2'b11
	} addr2Sel_t;

	typedef struct packed
	{
		logic ldMar;
		logic ldMdr;
		logic ldIr;
		logic ldBen;
		logic ldCc;
		logic ldReg;
		logic ldPc;
		logic ldLed;
		logic gatePc;
		logic gateMdr;
		logic gateAlu;
		logic gateMarmux;
		pcSel_t pcMux;
		addr2Sel_t addr2Mux;
		aluOp_t aluK;
		logic drMux;	// High writes R7 instead of IR[11:9].
		logic sr1Mux;	// High reads IR[11:9] instead of IR[8:6].
		logic sr2Mux;	// High takes imm5 as the second ALU operand.
		logic addr1Mux;	// High uses SR1 as base instead of the PC.
		logic mioEn;	// High loads MDR from memory.
	} ctrl_t;

endpackage

//--- source/pcUnit.sv
`timescale 1ns/100ps

module pcUnit
#(
	parameter lc3Pkg::word_t resetPc = 16'h3000
)
(
	input logic Clk,
	input logic rstN,
	input lc3Pkg::ctrl_t ctrl,
	input lc3Pkg::word_t bus,
	input lc3Pkg::word_t addrOut,
	output lc3Pkg::word_t pc
);

	lc3Pkg::word_t pcPlusOne;
	lc3Pkg::word_t pcNext;

	assign pcPlusOne = pc + 16'd1;	// Wraps past 16'hFFFF.

	always_comb
	begin
		case (ctrl.pcMux)
			lc3Pkg::pcInc:
				pcNext = pcPlusOne;
			lc3Pkg::pcAddr:
				pcNext = addrOut;
			lc3Pkg::pcBus:
				pcNext = bus;
			default:
				pcNext = pcPlusOne;	// Unused encoding behaves like an increment.
		endcase
	end

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			pc <= resetPc;
		end
		else if (ctrl.ldPc)
		begin
			pc <= pcNext;
		end
	end

endmodule

//--- source/regFile.sv
`timescale 1ns/100ps

module regFile
(
	input logic Clk,
	input logic rstN,
	input lc3Pkg::ctrl_t ctrl,
	input lc3Pkg::word_t ir,
	input lc3Pkg::word_t bus,
	output lc3Pkg::word_t sr1Data,
	output lc3Pkg::word_t sr2Data
);

	lc3Pkg::word_t regs [8];
	lc3Pkg::regAddr_t drAddr;
	lc3Pkg::regAddr_t sr1Addr;
	lc3Pkg::regAddr_t sr2Addr;

	// JSR and TRAP link through R7, everything else names DR in IR[11:9].
	always_comb
	begin
		if (ctrl.drMux)
		begin
			drAddr = 3'd7;
		end
		else
		begin
			drAddr = ir[11:9];
		end
	end

	// Stores read their source from IR[11:9].
	assign sr1Addr = ctrl.sr1Mux ? ir[11:9] : ir[8:6];
	assign sr2Addr = ir[2:0];

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < 8; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (ctrl.ldReg)
		begin
			regs[drAddr] <= bus;
		end
	end

	// Reads see the value from before a write in the same cycle.
	assign sr1Data = regs[sr1Addr];
	assign sr2Data = regs[sr2Addr];

endmodule

//--- source/aluUnit.sv
`timescale 1ns/100ps

module aluUnit
(
	input lc3Pkg::ctrl_t ctrl,
	input lc3Pkg::word_t ir,
	input lc3Pkg::word_t sr1Data,
	input lc3Pkg::word_t sr2Data,
	output lc3Pkg::word_t aluOut
);

	lc3Pkg::word_t imm5;
	lc3Pkg::word_t operandB;

	assign imm5 = {{11{ir[4]}}, ir[4:0]};

	always_comb
	begin
		if (ctrl.sr2Mux)
		begin
			operandB = imm5;
		end
		else
		begin
			operandB = sr2Data;
		end
	end

	always_comb
	begin
		case (ctrl.aluK)
			lc3Pkg::aluAdd:
				aluOut = sr1Data + operandB;
			lc3Pkg::aluAnd:
				aluOut = sr1Data & operandB;
			lc3Pkg::aluNot:
				aluOut = ~sr1Data;
			default:
				aluOut = sr1Data;	// Pass, used by stores and LEA-style moves.
		endcase
	end

endmodule

//--- source/addrUnit.sv
`timescale 1ns/100ps

module addrUnit
(
	input lc3Pkg::ctrl_t ctrl,
	input lc3Pkg::word_t ir,
	input lc3Pkg::word_t pc,
	input lc3Pkg::word_t sr1Data,
	output lc3Pkg::word_t addrOut
);

	lc3Pkg::word_t base;
	lc3Pkg::word_t offset;

	// Base register for LDR, STR and JMP, the PC for everything PC-relative.
	always_comb
	begin
		if (ctrl.addr1Mux)
		begin
			base = sr1Data;
		end
		else
		begin
			base = pc;
		end
	end

	always_comb
	begin
		case (ctrl.addr2Mux)
			lc3Pkg::off6:
				offset = {{10{ir[5]}}, ir[5:0]};
			lc3Pkg::off9:
				offset = {{7{ir[8]}}, ir[8:0]};
			lc3Pkg::off11:
				offset = {{5{ir[10]}}, ir[10:0]};
			default:
				offset = '0;
		endcase
	end

	assign addrOut = base + offset;	// Also drives the MARMUX gate.

endmodule

//--- source/memInterface.sv
`timescale 1ns/100ps

module memInterface
(
	input logic Clk,
	input logic rstN,
	input lc3Pkg::ctrl_t ctrl,
	input lc3Pkg::word_t bus,
	input lc3Pkg::word_t memDataIn,
	output lc3Pkg::word_t mar,
	output lc3Pkg::word_t mdr
);

	lc3Pkg::word_t mdrNext;

	// A memory read returns data with mioEn high, a store stages the bus.
	always_comb
	begin
		if (ctrl.mioEn)
		begin
			mdrNext = memDataIn;
		end
		else
		begin
			mdrNext = bus;
		end
	end

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			mar <= '0;
			mdr <= '0;
		end
		else
		begin
			if (ctrl.ldMar)
				mar <= bus;
			if (ctrl.ldMdr)
				mdr <= mdrNext;
		end
	end

endmodule

//--- source/condCodes.sv
`timescale 1ns/100ps

module condCodes
(
	input logic Clk,
	input logic rstN,
	input lc3Pkg::ctrl_t ctrl,
	input lc3Pkg::word_t bus,
	input lc3Pkg::word_t ir,
	output logic ben
);

	lc3Pkg::nzp_t nzp;
	lc3Pkg::nzp_t nzpNext;
	logic busZero;

	assign busZero = (bus == '0);
	assign nzpNext = {bus[15], busZero, !bus[15] && !busZero};	// Always one-hot.

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			nzp <= '0;
			ben <= 1'b0;
		end
		else
		begin
			if (ctrl.ldCc)
				nzp <= nzpNext;
			if (ctrl.ldBen)
				ben <= |(ir[11:9] & nzp);	// Compares against the flags held now.
		end
	end

endmodule

//--- source/lc3Datapath.sv
`timescale 1ns/100ps

module lc3Datapath
#(
	parameter lc3Pkg::word_t resetPc = 16'h3000
)
(
	input logic Clk,
	input logic rstN,
	input lc3Pkg::ctrl_t ctrl,
	input lc3Pkg::word_t memDataIn,
	output lc3Pkg::word_t mar,
	output lc3Pkg::word_t mdr,
	output lc3Pkg::word_t ir,
	output lc3Pkg::word_t pc,
	output logic ben,
	output lc3Pkg::word_t led
);

	lc3Pkg::word_t bus;
	lc3Pkg::word_t aluOut;
	lc3Pkg::word_t addrOut;
	lc3Pkg::word_t sr1Data;
	lc3Pkg::word_t sr2Data;

	// Only one gate should be on, the order just keeps the bus defined if not.
	always_comb
	begin
		if (ctrl.gateMdr)
			bus = mdr;
		else if (ctrl.gateAlu)
			bus = aluOut;
		else if (ctrl.gatePc)
			bus = pc;
		else if (ctrl.gateMarmux)
			bus = addrOut;
		else
			bus = '0;
	end

	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			ir <= '0;
			led <= '0;
		end
		else
		begin
			if (ctrl.ldIr)
				ir <= bus;
			if (ctrl.ldLed)
				led <= {6'b0, ir[9:0]};	// Trap vector shown on the board LEDs.
		end
	end

	pcUnit #(
		.resetPc(resetPc)
	) i_pcUnit (
		.Clk(Clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.bus(bus),
		.addrOut(addrOut),
		.pc(pc)
	);

	regFile i_regFile (
		.Clk(Clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.ir(ir),
		.bus(bus),
		.sr1Data(sr1Data),
		.sr2Data(sr2Data)
	);

	aluUnit i_aluUnit (
		.ctrl(ctrl),
		.ir(ir),
		.sr1Data(sr1Data),
		.sr2Data(sr2Data),
		.aluOut(aluOut)
	);

	addrUnit i_addrUnit (
		.ctrl(ctrl),
		.ir(ir),
		.pc(pc),
		.sr1Data(sr1Data),
		.addrOut(addrOut)
	);

	memInterface i_memInterface (
		.Clk(Clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.bus(bus),
		.memDataIn(memDataIn),
		.mar(mar),
		.mdr(mdr)
	);

	condCodes i_condCodes (
		.Clk(Clk),
		.rstN(rstN),
		.ctrl(ctrl),
		.bus(bus),
		.ir(ir),
		.ben(ben)
	);

endmodule

//--- testbench/lc3Datapath_sva.sv
`timescale 1ns/100ps

module lc3DatapathChecker
#(
	parameter lc3Pkg::word_t resetPc = 16'h3000
)
(
	input logic Clk,
	input logic rstN,
	input lc3Pkg::ctrl_t ctrl,
	input lc3Pkg::word_t pc,
	input lc3Pkg::nzp_t nzp
);

	gateExclusive: assert property (@(posedge Clk)
		$onehot0({ctrl.gatePc, ctrl.gateMdr, ctrl.gateAlu, ctrl.gateMarmux}))
		else $error("More than one bus gate is on.");

	pcAfterReset: assert property (@(posedge Clk) !rstN |=> pc == resetPc)
		else $error("PC does not hold its reset value after reset.");

	// Flags are one-hot once loaded, whatever the bus held.
	flagsOneHot: assert property (@(posedge Clk) rstN && ctrl.ldCc |=> $onehot(nzp))
		else $error("Condition codes are not one-hot after a flag load.");

endmodule

bind lc3Datapath lc3DatapathChecker #(
	.resetPc(resetPc)
) i_lc3DatapathChecker (
	.Clk(Clk),
	.rstN(rstN),
	.ctrl(ctrl),
	.pc(pc),
	.nzp(i_condCodes.nzp)
);

//--- testbench/lc3DatapathTb.sv
`timescale 1ns/100ps

module lc3DatapathTb;

	typedef struct
	{
		string name;
		lc3Pkg::ctrl_t ctrl;
		lc3Pkg::word_t mem;
		logic [5:0] mask;	// mar, mdr, ir, pc, ben, led from the top bit down.
		lc3Pkg::word_t expected;	// Value every checked output must show.
	} rowEntry_t;

	localparam logic [11:0] ldMarA = 12'h800;
	localparam logic [11:0] ldMdrA = 12'h400;
	localparam logic [11:0] ldIrA = 12'h200;
	localparam logic [11:0] ldBenA = 12'h100;
	localparam logic [11:0] ldCcA = 12'h080;
	localparam logic [11:0] ldRegA = 12'h040;
	localparam logic [11:0] ldPcA = 12'h020;
	localparam logic [11:0] ldLedA = 12'h010;
	localparam logic [11:0] gPcA = 12'h008;
	localparam logic [11:0] gMdrA = 12'h004;
	localparam logic [11:0] gAluA = 12'h002;
	localparam logic [11:0] gMarmuxA = 12'h001;

	// Select fields follow struct order with pcMux first and aluK last.
	localparam logic [5:0] selPcAddr9 = {lc3Pkg::pcAddr, lc3Pkg::off9, lc3Pkg::aluAdd};
	localparam logic [5:0] selPcBus = {lc3Pkg::pcBus, lc3Pkg::off0, lc3Pkg::aluAdd};
	localparam logic [5:0] selAnd = {lc3Pkg::pcInc, lc3Pkg::off0, lc3Pkg::aluAnd};
	localparam logic [5:0] selNot = {lc3Pkg::pcInc, lc3Pkg::off0, lc3Pkg::aluNot};
	localparam logic [5:0] selOff6 = {lc3Pkg::pcInc, lc3Pkg::off6, lc3Pkg::aluAdd};
	localparam logic [5:0] selOff11 = {lc3Pkg::pcInc, lc3Pkg::off11, lc3Pkg::aluAdd};

	localparam logic [4:0] drMuxA = 5'b10000;
	localparam logic [4:0] sr2MuxA = 5'b00100;
	localparam logic [4:0] addr1A = 5'b00010;
	localparam logic [4:0] mioA = 5'b00001;

	localparam logic [5:0] chkMar = 6'b100000;
	localparam logic [5:0] chkMdr = 6'b010000;
	localparam logic [5:0] chkIr = 6'b001000;
	localparam logic [5:0] chkPc = 6'b000100;
	localparam logic [5:0] chkBen = 6'b000010;
	localparam logic [5:0] chkLed = 6'b000001;

	logic Clk;
	logic rstN;
	lc3Pkg::ctrl_t ctrl;
	lc3Pkg::word_t memDataIn;
	lc3Pkg::word_t mar, mdr, ir, pc, led;
	logic ben;
	rowEntry_t table_[$];
	int errors;
	int waitCount;

	lc3Datapath i_lc3Datapath (
		.Clk(Clk), .rstN(rstN), .ctrl(ctrl), .memDataIn(memDataIn),
		.mar(mar), .mdr(mdr), .ir(ir), .pc(pc), .ben(ben), .led(led)
	);

	initial
	begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	function automatic lc3Pkg::ctrl_t makeCtrl(input logic [11:0] act, input logic [5:0] sel,
		input logic [4:0] misc);
		makeCtrl = {act, sel, misc};
	endfunction

	task automatic addRow(input string name, input lc3Pkg::ctrl_t c, input lc3Pkg::word_t mem,
		input logic [5:0] mask, input lc3Pkg::word_t expected);
		rowEntry_t r;
		r.name = name;
		r.ctrl = c;
		r.mem = mem;
		r.mask = mask;
		r.expected = expected;
		table_.push_back(r);
	endtask

	task automatic compareWord(input string name, input string what, input lc3Pkg::word_t exp,
		input lc3Pkg::word_t act);
		if (act !== exp)
		begin
			$display("** Error: %s %s expected %h actual %h", name, what, exp, act);
			errors++;
		end
	endtask

	initial
	begin
		rstN = 1'b0;
		ctrl = '0;
		memDataIn = '0;
		errors = 0;
		addRow("resetZero", makeCtrl(0, 0, 0), 0, chkMar | chkMdr | chkIr | chkBen | chkLed, 0);
		addRow("resetPc", makeCtrl(0, 0, 0), 0, chkPc, 16'h3000);
		addRow("pcInc", makeCtrl(ldPcA, 0, 0), 0, chkPc, 16'h3001);
		addRow("pcToMar", makeCtrl(gPcA | ldMarA, 0, 0), 0, chkMar, 16'h3001);
		addRow("fetchMdr", makeCtrl(ldMdrA, 0, mioA), 16'h0FFE, chkMdr, 16'h0FFE);
		addRow("fetchIr", makeCtrl(gMdrA | ldIrA | ldMdrA, 0, mioA), 16'h1234, chkIr, 16'h0FFE);
		addRow("fetchLed", makeCtrl(ldLedA, 0, 0), 0, chkLed, 16'h03FE);
		addRow("pcAddr", makeCtrl(ldPcA, selPcAddr9, 0), 0, chkPc, 16'h2FFF);
		addRow("writeR7", makeCtrl(gMdrA | ldRegA, 0, drMuxA), 0, chkMdr, 16'h1234);
		addRow("pcBus", makeCtrl(gMdrA | ldPcA | ldMdrA, selPcBus, mioA), 16'h11C0, chkPc, 16'h1234);
		addRow("loadIrA", makeCtrl(gMdrA | ldIrA | ldMdrA, 0, mioA), 16'h0F0F, chkIr, 16'h11C0);
		addRow("writeR0", makeCtrl(gMdrA | ldRegA, 0, 0), 0, chkMdr, 16'h0F0F);
		addRow("addReg", makeCtrl(gAluA | ldMarA, 0, 0), 0, chkMar, 16'h2143);
		addRow("andReg", makeCtrl(gAluA | ldMarA, selAnd, 0), 0, chkMar, 16'h0204);
		addRow("notReg", makeCtrl(gAluA | ldMarA, selNot, 0), 0, chkMar, 16'hEDCB);
		addRow("mdrIrB", makeCtrl(ldMdrA, 0, mioA), 16'h11FD, chkMdr, 16'h11FD);
		addRow("loadIrB", makeCtrl(gMdrA | ldIrA | ldMdrA, 0, mioA), 16'h8800, chkIr, 16'h11FD);
		addRow("addImm", makeCtrl(gAluA | ldMarA, 0, sr2MuxA), 0, chkMar, 16'h1231);
		addRow("ccNeg", makeCtrl(gMdrA | ldIrA | ldCcA | ldMdrA, 0, mioA), 16'h8200, chkIr, 16'h8800);
		addRow("benNegHit", makeCtrl(ldBenA, 0, 0), 0, chkBen, 16'h0001);
		addRow("loadIrNoN", makeCtrl(gMdrA | ldIrA | ldMdrA, 0, mioA), 16'h0400, chkIr, 16'h8200);
		addRow("benNegMiss", makeCtrl(ldBenA, 0, 0), 0, chkBen, 16'h0000);
		addRow("ccZero", makeCtrl(ldCcA, 0, 0), 0, chkBen, 16'h0000);	// Empty bus reads as zero.
		addRow("loadIrZ", makeCtrl(gMdrA | ldIrA | ldMdrA, 0, mioA), 16'h0200, chkIr, 16'h0400);
		addRow("benZeroHit", makeCtrl(ldBenA, 0, 0), 0, chkBen, 16'h0001);
		addRow("loadIrNoZ", makeCtrl(gMdrA | ldIrA | ldMdrA, 0, mioA), 16'h0400, chkIr, 16'h0200);
		addRow("benZeroMiss", makeCtrl(ldBenA, 0, 0), 0, chkBen, 16'h0000);
		addRow("ccPos", makeCtrl(gMdrA | ldCcA | ldMdrA, 0, mioA), 16'h0400, chkMdr, 16'h0400);
		addRow("benPosHit", makeCtrl(ldBenA, 0, 0), 0, chkBen, 16'h0001);
		addRow("loadIrNoP", makeCtrl(gMdrA | ldIrA | ldMdrA, 0, mioA), 16'h01F0, chkIr, 16'h0400);
		addRow("benPosMiss", makeCtrl(ldBenA, 0, 0), 0, chkBen, 16'h0000);
		addRow("loadIrEa", makeCtrl(gMdrA | ldIrA, 0, 0), 0, chkIr, 16'h01F0);
		addRow("eaBaseOff6", makeCtrl(gMarmuxA | ldMarA, selOff6, addr1A), 0, chkMar, 16'h1224);
		addRow("eaPcOff11", makeCtrl(gMarmuxA | ldMarA, selOff11, 0), 0, chkMar, 16'h1424);

		repeat (8) @(posedge Clk);
		rstN <= 1'b1;
		waitCount = 0;
		while (pc !== 16'h3000 && waitCount < 20)
		begin
			@(posedge Clk);
			waitCount++;
		end
		if (pc !== 16'h3000)
		begin
			$display("The PC did not show its reset value within 20 cycles of reset.");
			$display("Verification failed");
			$finish;
		end
		else
		begin
			foreach (table_[i])
			begin
				@(posedge Clk);
				ctrl <= table_[i].ctrl;
				memDataIn <= table_[i].mem;
				@(posedge Clk);
				ctrl <= '0;	// The load happens on this edge and all strobes drop after it.
				@(negedge Clk);
				if (table_[i].mask[5])
					compareWord(table_[i].name, "mar", table_[i].expected, mar);
				if (table_[i].mask[4])
					compareWord(table_[i].name, "mdr", table_[i].expected, mdr);
				if (table_[i].mask[3])
					compareWord(table_[i].name, "ir", table_[i].expected, ir);
				if (table_[i].mask[2])
					compareWord(table_[i].name, "pc", table_[i].expected, pc);
				if (table_[i].mask[1])
					compareWord(table_[i].name, "ben", table_[i].expected, {15'b0, ben});
				if (table_[i].mask[0])
					compareWord(table_[i].name, "led", table_[i].expected, led);
			end
			$display("Rows applied: %0d, errors: %0d", table_.size(), errors);
			if (errors == 0)
				$display("Verification passed");
			else
				$display("Verification failed");
			$finish;
		end
	end

endmodule

//--- sources.f
source/lc3Pkg.sv
source/pcUnit.sv
source/regFile.sv
source/aluUnit.sv
source/addrUnit.sv
source/memInterface.sv
source/condCodes.sv
source/lc3Datapath.sv
testbench/lc3Datapath_sva.sv
testbench/lc3DatapathTb.sv

//--- Bender.yml
package:
  name: lc3_datapath

sources:
  - files:
      - source/lc3Pkg.sv
      - source/pcUnit.sv
      - source/regFile.sv
      - source/aluUnit.sv
      - source/addrUnit.sv
      - source/memInterface.sv
      - source/condCodes.sv
      - source/lc3Datapath.sv
  - target: test
    files:
      - testbench/lc3Datapath_sva.sv
      - testbench/lc3DatapathTb.sv
